/* sources.f */
+incdir+logic
logic/exu_pkg.sv
logic/exu_regfile.sv
logic/exu_bypass.sv
logic/exu_alu.sv
logic/exu_branch.sv
logic/exu_pipe.sv
logic/exu_top.sv
test/exu_tb.sv

/* test/exu_tb.sv */
`default_nettype none

`include "exu_cfg.svh"

module exu_tb;

   localparam int MAX_ROWS = 80;

   logic                 clk;
   logic                 rst_n;
   exu_pkg::dec_inst_t   dec;
   logic                 branch;
   logic [`EXU_XLEN-1:0] brn_addr;
   exu_pkg::wb_rec_t     wb;

   // stimulus and expected outcome per row
   string                names [MAX_ROWS];
   exu_pkg::dec_inst_t   insts [MAX_ROWS];
   logic                 exp_commit [MAX_ROWS];
   logic [`EXU_RA_W-1:0] exp_rd [MAX_ROWS];
   logic [`EXU_XLEN-1:0] exp_data [MAX_ROWS];
   logic                 exp_br [MAX_ROWS];
   logic [`EXU_XLEN-1:0] exp_tgt [MAX_ROWS];

   int   n_rows = 0;
   int   pass_cnt = 0;
   int   fail_cnt = 0;
   logic table_built = 1'b0;
   int   pending [$];

   exu_top exu_top_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .dec      (dec),
      .branch   (branch),
      .brn_addr (brn_addr),
      .wb       (wb)
   );

   always #10 clk = ~clk;

   // pc follows the row position, 4 bytes apart from 'h1000
   function automatic exu_pkg::dec_inst_t base_inst();
      exu_pkg::dec_inst_t d;
      d = '0;
      d.vld = 1'b1;
      d.pc = `EXU_XLEN'(32'h1000 + 4 * n_rows);
      return d;
   endfunction

   task automatic store_row(input string name, input exu_pkg::dec_inst_t d, input logic commit,
                            input logic [`EXU_RA_W-1:0] rd, input logic [`EXU_XLEN-1:0] data,
                            input logic br, input logic [`EXU_XLEN-1:0] tgt);
      names[n_rows] = name;
      insts[n_rows] = d;
      exp_commit[n_rows] = commit;
      exp_rd[n_rows] = rd;
      exp_data[n_rows] = data;
      exp_br[n_rows] = br;
      exp_tgt[n_rows] = tgt;
      n_rows++;
   endtask

   task automatic alu_row(input string name, input exu_pkg::alu_op_e op,
                          input logic [`EXU_RA_W-1:0] rs1, rs2, rd,
                          input logic [`EXU_XLEN-1:0] imm, input logic a_pc, input logic b_imm,
                          input logic [`EXU_XLEN-1:0] res);
      exu_pkg::dec_inst_t d;
      d = base_inst();
      d.rs1 = rs1;
      d.rs2 = rs2;
      d.rd = rd;
      d.wen = 1'b1;
      d.imm = imm;
      d.alu_vld = 1'b1;
      d.alu_op = op;
      d.alu_a_pc = a_pc;
      d.alu_b_imm = b_imm;
      store_row(name, d, 1'b1, rd, res, 1'b0, '0);
   endtask

   // rd of zero means no link write
   task automatic bru_row(input string name, input exu_pkg::bru_op_e op,
                          input logic [`EXU_RA_W-1:0] rs1, rs2, rd,
                          input logic [`EXU_XLEN-1:0] offset, input logic taken,
                          input logic [`EXU_XLEN-1:0] target, input logic [`EXU_XLEN-1:0] link);
      exu_pkg::dec_inst_t d;
      d = base_inst();
      d.rs1 = rs1;
      d.rs2 = rs2;
      d.rd = rd;
      d.wen = (rd != '0);
      d.bru_vld = 1'b1;
      d.bru_op = op;
      d.bru_offset = offset;
      store_row(name, d, d.wen, rd, link, taken, target);
   endtask

   // three rows behind a taken branch, each would commit or branch if issued
   task automatic shadow_rows(input string after);
      exu_pkg::dec_inst_t d;
      int k;
      for (k = 1; k <= 3; k++) begin
         d = base_inst();
         if (k == 2) begin
            d.bru_vld = 1'b1;
            d.bru_op = exu_pkg::BRU_B;
            d.bru_offset = 32'h40;
         end else begin
            d.rd = 5'd22;
            d.wen = 1'b1;
            d.alu_vld = 1'b1;
            d.alu_op = exu_pkg::ALU_PASSB;
            d.alu_b_imm = 1'b1;
            d.imm = 32'hbad;
         end
         store_row($sformatf("%s_sq%0d", after, k), d, 1'b0, '0, '0, 1'b0, '0);
      end
   endtask

   task automatic build_table();
      // constants, then every alu op with register, immediate and pc operands
      alu_row("li_r1", exu_pkg::ALU_PASSB, 5'd0, 5'd0, 5'd1, 32'h5, 1'b0, 1'b1, 32'h5);
      alu_row("li_r2", exu_pkg::ALU_PASSB, 5'd0, 5'd0, 5'd2, 32'hffff_fff0, 1'b0, 1'b1,
              32'hffff_fff0);
      alu_row("add_rr", exu_pkg::ALU_ADD, 5'd1, 5'd2, 5'd3, 32'h0, 1'b0, 1'b0, 32'hffff_fff5);
      alu_row("sub_rr", exu_pkg::ALU_SUB, 5'd1, 5'd2, 5'd4, 32'h0, 1'b0, 1'b0, 32'h15);
      alu_row("and_imm", exu_pkg::ALU_AND, 5'd3, 5'd0, 5'd5, 32'hff, 1'b0, 1'b1, 32'hf5);
      alu_row("or_imm", exu_pkg::ALU_OR, 5'd5, 5'd0, 5'd6, 32'h300, 1'b0, 1'b1, 32'h3f5);
      alu_row("xor_rr", exu_pkg::ALU_XOR, 5'd6, 5'd4, 5'd7, 32'h0, 1'b0, 1'b0, 32'h3e0);
      alu_row("slt_rr", exu_pkg::ALU_SLT, 5'd2, 5'd1, 5'd8, 32'h0, 1'b0, 1'b0, 32'h1);
      alu_row("sltu_rr", exu_pkg::ALU_SLTU, 5'd2, 5'd1, 5'd9, 32'h0, 1'b0, 1'b0, 32'h0);
      alu_row("sll_imm", exu_pkg::ALU_SLL, 5'd1, 5'd0, 5'd10, 32'h4, 1'b0, 1'b1, 32'h50);
      alu_row("srl_rr", exu_pkg::ALU_SRL, 5'd2, 5'd1, 5'd11, 32'h0, 1'b0, 1'b0, 32'h07ff_ffff);
      alu_row("sra_imm", exu_pkg::ALU_SRA, 5'd2, 5'd0, 5'd12, 32'h4, 1'b0, 1'b1, 32'hffff_ffff);
      alu_row("add_pc", exu_pkg::ALU_ADD, 5'd0, 5'd0, 5'd13, 32'h100, 1'b1, 1'b1, 32'h1130);
      alu_row("sub_pc", exu_pkg::ALU_SUB, 5'd0, 5'd4, 5'd14, 32'h0, 1'b1, 1'b0, 32'h101f);
      // register 0 writes show on wb but never read back
      alu_row("wr_r0", exu_pkg::ALU_ADD, 5'd1, 5'd0, 5'd0, 32'h7, 1'b0, 1'b1, 32'hc);
      alu_row("r0_dist1", exu_pkg::ALU_ADD, 5'd0, 5'd0, 5'd15, 32'h0, 1'b0, 1'b1, 32'h0);
      alu_row("r0_dist2", exu_pkg::ALU_OR, 5'd0, 5'd1, 5'd16, 32'h0, 1'b0, 1'b0, 32'h5);
      alu_row("r0_dist3", exu_pkg::ALU_ADD, 5'd0, 5'd3, 5'd17, 32'h0, 1'b0, 1'b0, 32'hffff_fff5);
      // M result beats the older W result
      alu_row("li_r20_a", exu_pkg::ALU_PASSB, 5'd0, 5'd0, 5'd20, 32'h11, 1'b0, 1'b1, 32'h11);
      alu_row("li_r20_b", exu_pkg::ALU_PASSB, 5'd0, 5'd0, 5'd20, 32'h22, 1'b0, 1'b1, 32'h22);
      alu_row("m_over_w", exu_pkg::ALU_ADD, 5'd20, 5'd0, 5'd21, 32'h0, 1'b0, 1'b1, 32'h22);
      // r1 = 5, r2 = -16, r4 = 'h15, r16 = 5
      bru_row("beq_nt", exu_pkg::BRU_BEQ, 5'd1, 5'd4, 5'd0, 32'h40, 1'b0, '0, '0);
      bru_row("beq_t", exu_pkg::BRU_BEQ, 5'd16, 5'd1, 5'd0, 32'hffff_fff8, 1'b1, 32'h1050, '0);
      shadow_rows("beq_t");
      bru_row("bne_nt", exu_pkg::BRU_BNE, 5'd1, 5'd16, 5'd0, 32'h40, 1'b0, '0, '0);
      bru_row("bne_t", exu_pkg::BRU_BNE, 5'd1, 5'd4, 5'd0, 32'h20, 1'b1, 32'h108c, '0);
      shadow_rows("bne_t");
      bru_row("blt_nt", exu_pkg::BRU_BLT, 5'd1, 5'd2, 5'd0, 32'h40, 1'b0, '0, '0);
      bru_row("blt_t", exu_pkg::BRU_BLT, 5'd2, 5'd1, 5'd0, 32'h100, 1'b1, 32'h1180, '0);
      shadow_rows("blt_t");
      bru_row("bge_nt", exu_pkg::BRU_BGE, 5'd2, 5'd1, 5'd0, 32'h40, 1'b0, '0, '0);
      bru_row("bge_t", exu_pkg::BRU_BGE, 5'd1, 5'd2, 5'd0, 32'h8, 1'b1, 32'h109c, '0);
      shadow_rows("bge_t");
      bru_row("bltu_nt", exu_pkg::BRU_BLTU, 5'd2, 5'd1, 5'd0, 32'h40, 1'b0, '0, '0);
      bru_row("bltu_t", exu_pkg::BRU_BLTU, 5'd1, 5'd2, 5'd0, 32'hffff_ff00, 1'b1, 32'hfa8, '0);
      shadow_rows("bltu_t");
      bru_row("bgeu_nt", exu_pkg::BRU_BGEU, 5'd1, 5'd2, 5'd0, 32'h40, 1'b0, '0, '0);
      bru_row("bgeu_t", exu_pkg::BRU_BGEU, 5'd2, 5'd1, 5'd0, 32'h44, 1'b1, 32'h1100, '0);
      shadow_rows("bgeu_t");
      // jirl base comes from the row just before, through M
      alu_row("li_r24", exu_pkg::ALU_PASSB, 5'd0, 5'd0, 5'd24, 32'h2000, 1'b0, 1'b1, 32'h2000);
      bru_row("jirl_fwd", exu_pkg::BRU_JIRL, 5'd24, 5'd0, 5'd25, 32'h10, 1'b1, 32'h2010,
              32'h10d4);
      shadow_rows("jirl_fwd");
      bru_row("bl", exu_pkg::BRU_BL, 5'd0, 5'd0, 5'd26, 32'h200, 1'b1, 32'h12e0, 32'h10e4);
      shadow_rows("bl");
      // squashed writes to r22 must not have landed
      alu_row("chk_r22", exu_pkg::ALU_ADD, 5'd22, 5'd0, 5'd27, 32'h0, 1'b0, 1'b0, 32'h0);
      alu_row("chk_link", exu_pkg::ALU_SUB, 5'd26, 5'd25, 5'd28, 32'h0, 1'b0, 1'b0, 32'h10);
   endtask

   task automatic check_row(input int idx);
      logic ok;
      ok = 1'b1;
      if (exp_commit[idx]) begin
         if (wb.vld !== 1'b1) begin
            $display("%s: expected a commit on wb but none came", names[idx]);
            ok = 1'b0;
         end else begin
            if (wb.rd !== exp_rd[idx]) begin
               $display("** Error: %s wb.rd expected %0d actual %0d", names[idx], exp_rd[idx],
                        wb.rd);
               ok = 1'b0;
            end
            if (wb.data !== exp_data[idx]) begin
               $display("** Error: %s wb.data expected 'h%08h actual 'h%08h", names[idx],
                        exp_data[idx], wb.data);
               ok = 1'b0;
            end
         end
      end else if (wb.vld !== 1'b0) begin
         $display("%s: unexpected commit to r%0d", names[idx], wb.rd);
         ok = 1'b0;
      end
      if (exp_br[idx]) begin
         if (branch !== 1'b1) begin
            $display("%s: expected a taken branch but branch stayed low", names[idx]);
            ok = 1'b0;
         end else if (brn_addr !== exp_tgt[idx]) begin
            $display("** Error: %s brn_addr expected 'h%08h actual 'h%08h", names[idx],
                     exp_tgt[idx], brn_addr);
            ok = 1'b0;
         end
      end else if (branch !== 1'b0) begin
         $display("%s: unexpected branch to 'h%08h", names[idx], brn_addr);
         ok = 1'b0;
      end
      if (ok) begin
         pass_cnt++;
         $display("pass  %s", names[idx]);
      end else begin
         fail_cnt++;
         $display("FAIL  %s", names[idx]);
      end
   endtask

   // empty slot, nothing may come out
   task automatic check_bubble();
      if (wb.vld !== 1'b0 || branch !== 1'b0) begin
         $display("idle slot: commit or branch seen with no instruction in flight");
         fail_cnt++;
      end
   endtask

   initial begin
      wait (table_built);
      #((n_rows + 10) * 20);
      $display("watchdog expired before all rows were checked");
      $display("Test failed");
      $finish;
   end

   initial begin
      logic reset_ok;
      int   idx;
      int   i;
      clk = 1'b0;
      rst_n = 1'b0;
      dec = '0;
      build_table();
      table_built = 1'b1;
      reset_ok = 1'b1;
      repeat (4) begin
         @(negedge clk);
         if (branch !== 1'b0 || wb.vld !== 1'b0) begin
            reset_ok = 1'b0;
         end
      end
      rst_n = 1'b1;
      if (reset_ok) begin
         pass_cnt++;
         $display("pass  reset");
      end else begin
         fail_cnt++;
         $display("reset: branch or wb.vld not low while rst_n was asserted");
         $display("FAIL  reset");
      end
      // pipeline holds three empty slots coming out of reset
      repeat (3) pending.push_back(-1);
      for (i = 0; i < n_rows + 3; i++) begin
         idx = pending.pop_front();
         if (idx < 0) begin
            check_bubble();
         end else begin
            check_row(idx);
         end
         if (i < n_rows) begin
            dec = insts[i];
            pending.push_back(i);
         end else begin
            dec = '0;
            pending.push_back(-1);
         end
         @(negedge clk);
      end
      $display("%0d tests: %0d passed, %0d failed", n_rows + 1, pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* logic/exu_top.sv */
`default_nettype none

`include "exu_cfg.svh"

module exu_top (
   input  logic                 clk,
   input  logic                 rst_n,
   input  exu_pkg::dec_inst_t   dec,
   output logic                 branch,
   output logic [`EXU_XLEN-1:0] brn_addr,
   output exu_pkg::wb_rec_t     wb
);

   logic [`EXU_RA_W-1:0] rf_raddr_a;
   logic [`EXU_RA_W-1:0] rf_raddr_b;
   logic [`EXU_XLEN-1:0] rf_rdata_a;
   logic [`EXU_XLEN-1:0] rf_rdata_b;
   logic [`EXU_RA_W-1:0] rs1_e;
   logic [`EXU_RA_W-1:0] rs2_e;
   logic [`EXU_XLEN-1:0] rs1_data_e;
   logic [`EXU_XLEN-1:0] rs2_data_e;
   logic [`EXU_XLEN-1:0] rs1_fwd;
   logic [`EXU_XLEN-1:0] rs2_fwd;
   exu_pkg::alu_op_e     alu_op;
   exu_pkg::bru_op_e     bru_op;
   logic [`EXU_XLEN-1:0] alu_a;
   logic [`EXU_XLEN-1:0] alu_b;
   logic [`EXU_XLEN-1:0] alu_res;
   logic [`EXU_XLEN-1:0] bru_pc;
   logic [`EXU_XLEN-1:0] bru_offset;
   logic                 bru_vld;
   logic                 bru_taken;
   logic [`EXU_XLEN-1:0] bru_target;
   logic [`EXU_XLEN-1:0] bru_link;
   exu_pkg::wb_rec_t     wb_m;

   exu_pipe u_pipe (
      .clk        (clk),
      .rst_n      (rst_n),
      .dec        (dec),
      .rf_raddr_a (rf_raddr_a),
      .rf_raddr_b (rf_raddr_b),
      .rf_rdata_a (rf_rdata_a),
      .rf_rdata_b (rf_rdata_b),
      .rs1_e      (rs1_e),
      .rs2_e      (rs2_e),
      .rs1_data_e (rs1_data_e),
      .rs2_data_e (rs2_data_e),
      .rs1_fwd    (rs1_fwd),
      .rs2_fwd    (rs2_fwd),
      .alu_op     (alu_op),
      .bru_op     (bru_op),
      .alu_a      (alu_a),
      .alu_b      (alu_b),
      .bru_pc     (bru_pc),
      .bru_offset (bru_offset),
      .bru_vld    (bru_vld),
      .alu_res    (alu_res),
      .bru_taken  (bru_taken),
      .bru_target (bru_target),
      .bru_link   (bru_link),
      .wb_m       (wb_m),
      .wb_w       (wb),
      .branch     (branch),
      .brn_addr   (brn_addr)
   );

   // W record writes the registers and leaves as the trace port
   exu_regfile u_rf (
      .clk     (clk),
      .rst_n   (rst_n),
      .raddr_a (rf_raddr_a),
      .raddr_b (rf_raddr_b),
      .rdata_a (rf_rdata_a),
      .rdata_b (rf_rdata_b),
      .wb      (wb)
   );

   exu_bypass u_byp (
      .rs1_e      (rs1_e),
      .rs2_e      (rs2_e),
      .rs1_data_e (rs1_data_e),
      .rs2_data_e (rs2_data_e),
      .wb_m       (wb_m),
      .wb_w       (wb),
      .rs1_fwd    (rs1_fwd),
      .rs2_fwd    (rs2_fwd)
   );

   exu_alu u_alu (
      .op  (alu_op),
      .a   (alu_a),
      .b   (alu_b),
      .res (alu_res)
   );

   // branch compares the forwarded sources directly
   exu_branch u_bru (
      .op     (bru_op),
      .vld    (bru_vld),
      .a      (rs1_fwd),
      .b      (rs2_fwd),
      .pc     (bru_pc),
      .offset (bru_offset),
      .taken  (bru_taken),
      .target (bru_target),
      .link   (bru_link)
   );

endmodule

`default_nettype wire

/* logic/exu_pipe.sv */
`default_nettype none

`include "exu_cfg.svh"

module exu_pipe (
   input  logic                 clk,
   input  logic                 rst_n,
   input  exu_pkg::dec_inst_t   dec,
   output logic [`EXU_RA_W-1:0] rf_raddr_a,
   output logic [`EXU_RA_W-1:0] rf_raddr_b,
   input  logic [`EXU_XLEN-1:0] rf_rdata_a,
   input  logic [`EXU_XLEN-1:0] rf_rdata_b,
   output logic [`EXU_RA_W-1:0] rs1_e,
   output logic [`EXU_RA_W-1:0] rs2_e,
   output logic [`EXU_XLEN-1:0] rs1_data_e,
   output logic [`EXU_XLEN-1:0] rs2_data_e,
   input  logic [`EXU_XLEN-1:0] rs1_fwd,
   input  logic [`EXU_XLEN-1:0] rs2_fwd,
   output exu_pkg::alu_op_e     alu_op,
   output exu_pkg::bru_op_e     bru_op,
   output logic [`EXU_XLEN-1:0] alu_a,
   output logic [`EXU_XLEN-1:0] alu_b,
   output logic [`EXU_XLEN-1:0] bru_pc,
   output logic [`EXU_XLEN-1:0] bru_offset,
   output logic                 bru_vld,
   input  logic [`EXU_XLEN-1:0] alu_res,
   input  logic                 bru_taken,
   input  logic [`EXU_XLEN-1:0] bru_target,
   input  logic [`EXU_XLEN-1:0] bru_link,
   output exu_pkg::wb_rec_t     wb_m,
   output exu_pkg::wb_rec_t     wb_w,
   output logic                 branch,
   output logic [`EXU_XLEN-1:0] brn_addr
);

   typedef struct packed {
      logic                 alu_vld;
      logic                 bru_vld;
      logic                 wen;
      logic                 taken;
      logic [`EXU_RA_W-1:0] rd;
      logic [`EXU_XLEN-1:0] alu_res;
      logic [`EXU_XLEN-1:0] link;
      logic [`EXU_XLEN-1:0] target;
   } m_stage_t;

   exu_pkg::dec_inst_t   issue;
   exu_pkg::dec_inst_t   e_q;
   m_stage_t             m_q;
   logic                 taken_w;
   logic [`EXU_XLEN-1:0] target_w;
   logic                 flush;

   // redirect pending anywhere past decode
   assign flush = bru_taken | m_q.taken | taken_w;

   assign rf_raddr_a = dec.rs1;
   assign rf_raddr_b = dec.rs2;

   always_comb begin
      issue         = dec;
      issue.vld     = dec.vld & ~flush;
      issue.wen     = dec.vld & dec.wen & ~flush;
      issue.alu_vld = dec.vld & dec.alu_vld & ~flush;
      issue.bru_vld = dec.vld & dec.bru_vld & ~flush;
   end

   // E stage
   always_ff @(posedge clk) begin
      e_q        <= issue;
      rs1_data_e <= rf_rdata_a;
      rs2_data_e <= rf_rdata_b;
      if (!rst_n) begin
         e_q.vld     <= 1'b0;
         e_q.wen     <= 1'b0;
         e_q.alu_vld <= 1'b0;
         e_q.bru_vld <= 1'b0;
      end
   end

   assign rs1_e      = e_q.rs1;
   assign rs2_e      = e_q.rs2;
   assign alu_op     = e_q.alu_op;
   assign bru_op     = e_q.bru_op;
   assign alu_a      = e_q.alu_a_pc ? e_q.pc : rs1_fwd;
   assign alu_b      = e_q.alu_b_imm ? e_q.imm : rs2_fwd;
   assign bru_pc     = e_q.pc;
   assign bru_offset = e_q.bru_offset;
   assign bru_vld    = e_q.bru_vld;

   // M stage
   always_ff @(posedge clk) begin
      m_q.rd      <= e_q.rd;
      m_q.alu_res <= alu_res;
      m_q.link    <= bru_link;
      m_q.target  <= bru_target;
      if (!rst_n) begin
         m_q.alu_vld <= 1'b0;
         m_q.bru_vld <= 1'b0;
         m_q.wen     <= 1'b0;
         m_q.taken   <= 1'b0;
      end else begin
         m_q.alu_vld <= e_q.alu_vld;
         m_q.bru_vld <= e_q.bru_vld;
         m_q.wen     <= e_q.wen;
         m_q.taken   <= bru_taken;
      end
   end

   // result merge, at most one unit valid per instruction
   always_comb begin
      wb_m.vld  = m_q.wen;
      wb_m.rd   = m_q.rd;
      wb_m.data = ({`EXU_XLEN{m_q.alu_vld}} & m_q.alu_res) |
                  ({`EXU_XLEN{m_q.bru_vld}} & m_q.link);
   end

   // W stage
   always_ff @(posedge clk) begin
      wb_w.rd   <= wb_m.rd;
      wb_w.data <= wb_m.data;
      target_w  <= m_q.target;
      if (!rst_n) begin
         wb_w.vld <= 1'b0;
         taken_w  <= 1'b0;
      end else begin
         wb_w.vld <= wb_m.vld;
         taken_w  <= m_q.taken;
      end
   end

   assign branch   = taken_w;
   assign brn_addr = target_w;

endmodule

`default_nettype wire

/* logic/exu_branch.sv */
`default_nettype none

`include "exu_cfg.svh"

module exu_branch (
   input  exu_pkg::bru_op_e     op,
   input  logic                 vld,
   input  logic [`EXU_XLEN-1:0] a,
   input  logic [`EXU_XLEN-1:0] b,
   input  logic [`EXU_XLEN-1:0] pc,
   input  logic [`EXU_XLEN-1:0] offset,
   output logic                 taken,
   output logic [`EXU_XLEN-1:0] target,
   output logic [`EXU_XLEN-1:0] link
);

   logic cond;
   logic is_jirl;

   always_comb begin
      unique case (op)
         exu_pkg::BRU_BEQ:  cond = (a == b);
         exu_pkg::BRU_BNE:  cond = (a != b);
         exu_pkg::BRU_BLT:  cond = ($signed(a) < $signed(b));
         exu_pkg::BRU_BGE:  cond = ($signed(a) >= $signed(b));
         exu_pkg::BRU_BLTU: cond = (a < b);
         exu_pkg::BRU_BGEU: cond = (a >= b);
         // jumps always go
         exu_pkg::BRU_B,
         exu_pkg::BRU_BL,
         exu_pkg::BRU_JIRL: cond = 1'b1;
         default:           cond = 1'b0;
      endcase
   end

   assign taken = vld & cond;

   // register-indirect jump uses rs1 as base
   assign is_jirl = (op == exu_pkg::BRU_JIRL);
   assign target  = is_jirl ? (a + offset) : (pc + offset);

   assign link = pc + `EXU_XLEN'(`EXU_PC_STEP);

endmodule

`default_nettype wire

/* logic/exu_alu.sv */
`default_nettype none

`include "exu_cfg.svh"

module exu_alu (
   input  exu_pkg::alu_op_e     op,
   input  logic [`EXU_XLEN-1:0] a,
   input  logic [`EXU_XLEN-1:0] b,
   output logic [`EXU_XLEN-1:0] res
);

   logic [4:0] shamt;

   assign shamt = b[4:0];

   always_comb begin
      unique case (op)
         exu_pkg::ALU_ADD: begin
            res = a + b;
         end
         exu_pkg::ALU_SUB: begin
            res = a - b;
         end
         exu_pkg::ALU_AND: begin
            res = a & b;
         end
         exu_pkg::ALU_OR: begin
            res = a | b;
         end
         exu_pkg::ALU_XOR: begin
            res = a ^ b;
         end
         exu_pkg::ALU_SLT: begin
            res = {{(`EXU_XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
         end
         exu_pkg::ALU_SLTU: begin
            res = {{(`EXU_XLEN-1){1'b0}}, (a < b)};
         end
         exu_pkg::ALU_SLL: begin
            res = a << shamt;
         end
         exu_pkg::ALU_SRL: begin
            res = a >> shamt;
         end
         exu_pkg::ALU_SRA: begin
            res = $signed(a) >>> shamt;
         end
         exu_pkg::ALU_PASSB: begin
            // upper immediate arrives already shifted
            res = b;
         end
         default: begin
            res = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

/* logic/exu_bypass.sv */
`default_nettype none

`include "exu_cfg.svh"

module exu_bypass (
   input  logic [`EXU_RA_W-1:0] rs1_e,
   input  logic [`EXU_RA_W-1:0] rs2_e,
   input  logic [`EXU_XLEN-1:0] rs1_data_e,
   input  logic [`EXU_XLEN-1:0] rs2_data_e,
   input  exu_pkg::wb_rec_t     wb_m,
   input  exu_pkg::wb_rec_t     wb_w,
   output logic [`EXU_XLEN-1:0] rs1_fwd,
   output logic [`EXU_XLEN-1:0] rs2_fwd
);

   // youngest producer wins: M, then W, then the value read in decode
   function automatic logic [`EXU_XLEN-1:0] pick(input logic [`EXU_RA_W-1:0] rs,
                                                input logic [`EXU_XLEN-1:0] rf_val);
      logic [`EXU_XLEN-1:0] val;
      if (wb_m.vld && (wb_m.rd != '0) && (wb_m.rd == rs)) begin
         val = wb_m.data;
      end else if (wb_w.vld && (wb_w.rd != '0) && (wb_w.rd == rs)) begin
         val = wb_w.data;
      end else begin
         val = rf_val;
      end
      return val;
   endfunction

   always_comb begin
      rs1_fwd = pick(rs1_e, rs1_data_e);
      rs2_fwd = pick(rs2_e, rs2_data_e);
   end

endmodule

`default_nettype wire

/* logic/exu_regfile.sv */
`default_nettype none

`include "exu_cfg.svh"

module exu_regfile (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [`EXU_RA_W-1:0] raddr_a,
   input  logic [`EXU_RA_W-1:0] raddr_b,
   output logic [`EXU_XLEN-1:0] rdata_a,
   output logic [`EXU_XLEN-1:0] rdata_b,
   input  exu_pkg::wb_rec_t     wb
);

   logic [`EXU_XLEN-1:0] regs [`EXU_NREGS];
   logic                 wr_en;

   // register 0 is never written
   assign wr_en = wb.vld && (wb.rd != '0);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < `EXU_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wb.rd] <= wb.data;
      end
   end

   // write-through covers the instruction three behind
   function automatic logic [`EXU_XLEN-1:0] read_port(input logic [`EXU_RA_W-1:0] addr);
      logic [`EXU_XLEN-1:0] val;
      if (addr == '0) begin
         val = '0;
      end else if (wr_en && (addr == wb.rd)) begin
         val = wb.data;
      end else begin
         val = regs[addr];
      end
      return val;
   endfunction

   always_comb begin
      rdata_a = read_port(raddr_a);
      rdata_b = read_port(raddr_b);
   end

endmodule

`default_nettype wire

/* logic/exu_pkg.sv */
`default_nettype none

`include "exu_cfg.svh"

package exu_pkg;

   // alu operations, shifts use b[4:0]
   typedef enum logic [3:0] {
      ALU_ADD   = 4'd0,
      ALU_SUB   = 4'd1,
      ALU_AND   = 4'd2,
      ALU_OR    = 4'd3,
      ALU_XOR   = 4'd4,
      ALU_SLT   = 4'd5,
      ALU_SLTU  = 4'd6,
      ALU_SLL   = 4'd7,
      ALU_SRL   = 4'd8,
      ALU_SRA   = 4'd9,
      ALU_PASSB = 4'd10
   } alu_op_e;

   // branch operations
   typedef enum logic [3:0] {
      BRU_BEQ  = 4'd0,
      BRU_BNE  = 4'd1,
      BRU_BLT  = 4'd2,
      BRU_BGE  = 4'd3,
      BRU_BLTU = 4'd4,
      BRU_BGEU = 4'd5,
      BRU_B    = 4'd6,
      BRU_BL   = 4'd7,
      BRU_JIRL = 4'd8
   } bru_op_e;

   // one decoded instruction as presented by decode
   typedef struct packed {
      logic                 vld;
      logic [`EXU_XLEN-1:0] pc;
      logic [`EXU_RA_W-1:0] rs1;
      logic [`EXU_RA_W-1:0] rs2;
      logic [`EXU_RA_W-1:0] rd;
      logic                 wen;
      logic [`EXU_XLEN-1:0] imm;
      logic                 alu_vld;
      alu_op_e              alu_op;
      logic                 alu_a_pc;
      logic                 alu_b_imm;
      logic                 bru_vld;
      bru_op_e              bru_op;
      logic [`EXU_XLEN-1:0] bru_offset;
   } dec_inst_t;

   // register write-back and retirement record
   typedef struct packed {
      logic                 vld;
      logic [`EXU_RA_W-1:0] rd;
      logic [`EXU_XLEN-1:0] data;
   } wb_rec_t;

endpackage

`default_nettype wire

/* logic/exu_cfg.svh */
`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// data path and address width
`define EXU_XLEN 32

// register address width
`define EXU_RA_W 5

// number of integer registers, register 0 reads as zero
`define EXU_NREGS 32

// instruction size in bytes, also the link offset
`define EXU_PC_STEP 4

`endif
